// ==== verilog/gbt_cfg.svh ====
`ifndef GBT_CFG_SVH
`define GBT_CFG_SVH

// Timer block registers
`define GBT_ADDR_DIV  16'hFF04
`define GBT_ADDR_TIMA 16'hFF05
`define GBT_ADDR_TMA  16'hFF06
`define GBT_ADDR_TAC  16'hFF07

// Interrupt controller registers
`define GBT_ADDR_IF   16'hFF0F
`define GBT_ADDR_IE   16'hFFFF

// Request sources in IF and IE
`define GBT_NUM_IRQ 5

// Clocks per TIMA step minus one, indexed by TAC rate
`define GBT_RATE0_LIMIT 10'd1023
`define GBT_RATE1_LIMIT 10'd15
`define GBT_RATE2_LIMIT 10'd63
`define GBT_RATE3_LIMIT 10'd255

`endif

// ==== verilog/gbt_pkg.sv ====
package gbt_pkg;

  // Request from the CPU side, 26 bits
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        write_en;
    logic        read_en;
  } cpu_bus_t;

  // Request to one peripheral after address decode
  // Strobes arrive already gated by sel
  typedef struct packed {
    logic       sel;
    logic [1:0] reg_idx;
    logic [7:0] wdata;
    logic       write_en;
    logic       read_en;
  } periph_req_t;

  // Timer control byte
  // Written whole, decoded as enable and rate
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [4:0] unused;
      logic       enable;
      logic [1:0] rate;
    } fields;
  } tac_u;

  // Interrupt sources, lowest value has highest priority
  typedef enum logic [2:0] {
    irq_vblank = 3'd0,
    irq_stat   = 3'd1,
    irq_timer  = 3'd2,
    irq_serial = 3'd3,
    irq_joypad = 3'd4
  } irq_src_e;

endpackage

// ==== verilog/gbt_bus_fabric.sv ====
`timescale 1ns/10ps
`include "gbt_cfg.svh"

module gbt_bus_fabric (
  input  gbt_pkg::cpu_bus_t    bus,
  input  logic [7:0]           timer_rdata,
  input  logic [7:0]           int_rdata,
  output gbt_pkg::periph_req_t timer_req,
  output gbt_pkg::periph_req_t int_req,
  output logic [7:0]           rdata
);

  logic       timer_sel;
  logic       int_sel;
  logic [1:0] timer_idx;
  logic [1:0] int_idx;

  // Timer block decode
  // DIV 0, TIMA 1, TMA 2, TAC 3
  always_comb begin
    timer_sel = 1'b1;
    timer_idx = 2'd0;
    case (bus.addr)
      `GBT_ADDR_DIV:  timer_idx = 2'd0;
      `GBT_ADDR_TIMA: timer_idx = 2'd1;
      `GBT_ADDR_TMA:  timer_idx = 2'd2;
      `GBT_ADDR_TAC:  timer_idx = 2'd3;
      default:        timer_sel = 1'b0;
    endcase
  end

  // Interrupt controller decode
  // IF 0, IE 1
  always_comb begin
    int_sel = 1'b1;
    int_idx = 2'd0;
    case (bus.addr)
      `GBT_ADDR_IF: int_idx = 2'd0;
      `GBT_ADDR_IE: int_idx = 2'd1;
      default:      int_sel = 1'b0;
    endcase
  end

  // Strobes qualified by select here, once
  assign timer_req = '{
    sel:      timer_sel,
    reg_idx:  timer_idx,
    wdata:    bus.wdata,
    write_en: bus.write_en & timer_sel,
    read_en:  bus.read_en & timer_sel
  };

  assign int_req = '{
    sel:      int_sel,
    reg_idx:  int_idx,
    wdata:    bus.wdata,
    write_en: bus.write_en & int_sel,
    read_en:  bus.read_en & int_sel
  };

  // Read mux, open bus reads as all ones
  always_comb begin
    rdata = 8'hFF;
    if (timer_req.read_en) begin
      rdata = timer_rdata;
    end else if (int_req.read_en) begin
      rdata = int_rdata;
    end
  end

  // Address ranges of the two peripherals must not overlap
  sel_exclusive: assert final (!(timer_sel && int_sel))
    else $error("fabric selects timer and interrupt controller together");

endmodule

// ==== verilog/gbt_timer.sv ====
`timescale 1ns/10ps
`include "gbt_cfg.svh"

module gbt_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  gbt_pkg::periph_req_t req,
  output logic [7:0]           rdata,
  output logic                 timer_irq
);

  import gbt_pkg::*;

  // Only the upper byte of the divider is visible
  logic [15:0] div;
  logic [7:0]  tima;
  logic [7:0]  tma;
  tac_u        tac;

  // Clocks since the last TIMA step
  logic [9:0]  prescaler;
  logic [9:0]  rate_limit;

  logic        wr_div;
  logic        wr_tima;
  logic        wr_tma;
  logic        wr_tac;
  logic        step;
  logic        overflow;

  assign wr_div  = req.write_en && (req.reg_idx == 2'd0);
  assign wr_tima = req.write_en && (req.reg_idx == 2'd1);
  assign wr_tma  = req.write_en && (req.reg_idx == 2'd2);
  assign wr_tac  = req.write_en && (req.reg_idx == 2'd3);

  // Period select from TAC rate field
  always_comb begin
    case (tac.fields.rate)
      2'd0:    rate_limit = `GBT_RATE0_LIMIT;
      2'd1:    rate_limit = `GBT_RATE1_LIMIT;
      2'd2:    rate_limit = `GBT_RATE2_LIMIT;
      default: rate_limit = `GBT_RATE3_LIMIT;
    endcase
  end

  // At or above so that a rate change to a shorter period
  // still steps on the next edge
  assign step = tac.fields.enable && (prescaler >= rate_limit);

  // CPU write to TIMA cancels the step and its overflow
  assign overflow = step && (tima == 8'hFF) && !wr_tima;

  // Divider runs every clock and any write clears it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div <= 16'h0000;
    end else if (wr_div) begin
      div <= 16'h0000;
    end else begin
      div <= div + 16'd1;
    end
  end

  // Prescaler only advances while enabled
  // Untouched by DIV writes
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prescaler <= 10'd0;
    end else if (tac.fields.enable) begin
      if (step) begin
        prescaler <= 10'd0;
      end else begin
        prescaler <= prescaler + 10'd1;
      end
    end
  end

  // Counter, modulo and control
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tima      <= 8'h00;
      tma       <= 8'h00;
      tac.raw   <= 8'h00;
      timer_irq <= 1'b0;
    end else begin
      if (wr_tima) begin
        tima <= req.wdata;
      end else if (step) begin
        // Reload takes the TMA value from before this edge
        tima <= (tima == 8'hFF) ? tma : tima + 8'd1;
      end
      if (wr_tma) begin
        tma <= req.wdata;
      end
      if (wr_tac) begin
        // Enable and rate only
        tac.raw <= {5'b00000, req.wdata[2:0]};
      end
      // Request lasts one cycle after the overflow edge
      timer_irq <= overflow;
    end
  end

  // Register read with unused TAC bits read back as ones
  always_comb begin
    case (req.reg_idx)
      2'd0:    rdata = div[15:8];
      2'd1:    rdata = tima;
      2'd2:    rdata = tma;
      default: rdata = tac.raw | 8'hF8;
    endcase
  end

  // Back-to-back overflows need at least 16 clocks between them
  irq_single_cycle: assert property (
    @(posedge clk) disable iff (reset) timer_irq |=> !timer_irq
  ) else $error("timer_irq held for two cycles");

  // Prescaler sits above the limit only on the edge after a TAC write
  presc_in_range: assert property (
    @(posedge clk) disable iff (reset)
      (tac.fields.enable && (prescaler > rate_limit)) |-> $past(wr_tac)
  ) else $error("prescaler above the selected limit without a TAC write");

endmodule

// ==== verilog/gbt_int_ctrl.sv ====
`timescale 1ns/10ps
`include "gbt_cfg.svh"

module gbt_int_ctrl (
  input  logic                       clk,
  input  logic                       reset,
  input  gbt_pkg::periph_req_t       req,
  input  logic [`GBT_NUM_IRQ-1:0]    irq_in,
  input  logic                       irq_ack,
  output logic [7:0]                 rdata,
  output logic                       irq,
  output gbt_pkg::irq_src_e          irq_idx
);

  import gbt_pkg::*;

  // Flag and enable registers, one bit per source
  logic [`GBT_NUM_IRQ-1:0] if_reg;
  logic [`GBT_NUM_IRQ-1:0] ie_reg;

  logic [`GBT_NUM_IRQ-1:0] pending;
  logic [`GBT_NUM_IRQ-1:0] ack_mask;
  logic [`GBT_NUM_IRQ-1:0] if_base;

  logic wr_if;
  logic wr_ie;

  assign wr_if = req.write_en && (req.reg_idx == 2'd0);
  assign wr_ie = req.write_en && (req.reg_idx == 2'd1);

  assign pending = if_reg & ie_reg;
  assign irq     = |pending;

  // Lowest set bit wins
  // Scan from the top so lower indices overwrite
  always_comb begin
    irq_idx = irq_vblank;
    for (int i = `GBT_NUM_IRQ - 1; i >= 0; i--) begin
      if (pending[i]) begin
        irq_idx = irq_src_e'(i[2:0]);
      end
    end
  end

  // One-hot clear for the source being serviced
  assign ack_mask = irq_ack ? (`GBT_NUM_IRQ'(1) << irq_idx) : '0;

  // CPU write replaces flags, else ack clears one
  always_comb begin
    if (wr_if) begin
      if_base = req.wdata[`GBT_NUM_IRQ-1:0];
    end else begin
      if_base = if_reg & ~ack_mask;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      if_reg <= '0;
      ie_reg <= '0;
    end else begin
      // New requests always land, even on an ack or write edge
      if_reg <= if_base | irq_in;
      if (wr_ie) begin
        ie_reg <= req.wdata[`GBT_NUM_IRQ-1:0];
      end
    end
  end

  // Unimplemented IF bits read as ones, IE bits as zeros
  always_comb begin
    case (req.reg_idx)
      2'd0:    rdata = {3'b111, if_reg};
      2'd1:    rdata = {3'b000, ie_reg};
      default: rdata = 8'hFF;
    endcase
  end

  // CPU may only acknowledge a request it was shown
  ack_while_irq: assert property (
    @(posedge clk) disable iff (reset) irq_ack |-> irq
  ) else $error("irq_ack without pending irq");

endmodule

// ==== verilog/gbt_timer_subsys.sv ====
`timescale 1ns/10ps

module gbt_timer_subsys (
  input  logic              clk,
  input  logic              reset,
  input  gbt_pkg::cpu_bus_t bus,
  input  logic [4:0]        ext_irq,
  input  logic              irq_ack,
  output logic [7:0]        rdata,
  output logic              irq,
  output gbt_pkg::irq_src_e irq_idx
);

  import gbt_pkg::*;

  periph_req_t timer_req;
  periph_req_t int_req;
  logic [7:0]  timer_rdata;
  logic [7:0]  int_rdata;
  logic        timer_irq;
  logic [4:0]  irq_in;

  // Address decode and read mux
  gbt_bus_fabric u_fabric (
    .bus         (bus),
    .timer_rdata (timer_rdata),
    .int_rdata   (int_rdata),
    .timer_req   (timer_req),
    .int_req     (int_req),
    .rdata       (rdata)
  );

  // DIV, TIMA, TMA, TAC
  gbt_timer u_timer (
    .clk       (clk),
    .reset     (reset),
    .req       (timer_req),
    .rdata     (timer_rdata),
    .timer_irq (timer_irq)
  );

  // Timer owns bit 2, external bit there is dropped
  assign irq_in = {ext_irq[4:3], timer_irq, ext_irq[1:0]};

  // IF, IE and priority encoder
  gbt_int_ctrl u_int_ctrl (
    .clk     (clk),
    .reset   (reset),
    .req     (int_req),
    .irq_in  (irq_in),
    .irq_ack (irq_ack),
    .rdata   (int_rdata),
    .irq     (irq),
    .irq_idx (irq_idx)
  );

endmodule

// ==== sim/tb_gbt_timer_subsys.sv ====
`timescale 1ns/10ps
`include "gbt_cfg.svh"

module tb_gbt_timer_subsys;

  import gbt_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 8;
  localparam int MAP_CYCLES    = 14;
  localparam int HOLD_CYCLES   = 64;
  localparam int OVF_CYCLES    = 165;
  localparam int RANDOM_CYCLES = 4000;
  // Three TIMA periods per rate, plus TAC writes and the hold stretch
  localparam int RATE_CYCLES = 3 * (int'(`GBT_RATE0_LIMIT) + int'(`GBT_RATE1_LIMIT)
    + int'(`GBT_RATE2_LIMIT) + int'(`GBT_RATE3_LIMIT) + 4) + 4 * (26 + HOLD_CYCLES);
  localparam int TOTAL_CYCLES = RESET_CYCLES + 1 + MAP_CYCLES + RATE_CYCLES
    + OVF_CYCLES + RANDOM_CYCLES;
  localparam int MARGIN_CYCLES = 500;

  logic       clk;
  logic       reset;
  cpu_bus_t   bus;
  logic [4:0] ext_irq;
  logic       irq_ack;
  logic [7:0] rdata;
  logic       irq;
  irq_src_e   irq_idx;

  // Reference state, always the DUT state after the last edge
  logic [15:0] m_div;
  logic [9:0]  m_presc;
  logic [7:0]  m_tima;
  logic [7:0]  m_tma;
  tac_u        m_tac;
  logic        m_tirq;
  logic [4:0]  m_if;
  logic [4:0]  m_ie;

  gbt_timer_subsys dut (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus),
    .ext_irq (ext_irq),
    .irq_ack (irq_ack),
    .rdata   (rdata),
    .irq     (irq),
    .irq_idx (irq_idx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  function automatic cpu_bus_t read_req(input logic [15:0] addr);
    cpu_bus_t b;
    b = '0;
    b.addr = addr;
    b.read_en = 1'b1;
    return b;
  endfunction

  function automatic cpu_bus_t write_req(input logic [15:0] addr, input logic [7:0] data);
    cpu_bus_t b;
    b = '0;
    b.addr = addr;
    b.wdata = data;
    b.write_en = 1'b1;
    return b;
  endfunction

  // One of the six mapped registers
  function automatic logic [15:0] reg_addr(input int unsigned k);
    case (k % 6)
      0:       return `GBT_ADDR_DIV;
      1:       return `GBT_ADDR_TIMA;
      2:       return `GBT_ADDR_TMA;
      3:       return `GBT_ADDR_TAC;
      4:       return `GBT_ADDR_IF;
      default: return `GBT_ADDR_IE;
    endcase
  endfunction

  function automatic logic [9:0] limit_of(input logic [1:0] rate);
    case (rate)
      2'd0:    return `GBT_RATE0_LIMIT;
      2'd1:    return `GBT_RATE1_LIMIT;
      2'd2:    return `GBT_RATE2_LIMIT;
      default: return `GBT_RATE3_LIMIT;
    endcase
  endfunction

  function automatic logic writes(input cpu_bus_t b, input logic [15:0] addr);
    return b.write_en && (b.addr == addr);
  endfunction

  // Next edge is a TIMA step edge
  function automatic logic step_due();
    return m_tac.fields.enable && (m_presc >= limit_of(m_tac.fields.rate));
  endfunction

  function automatic logic model_irq();
    return |(m_if & m_ie);
  endfunction

  // Lowest enabled pending source, vblank when idle
  function automatic irq_src_e model_idx();
    logic [4:0] pend;
    logic       found;
    irq_src_e   idx;
    pend = m_if & m_ie;
    found = 1'b0;
    idx = irq_vblank;
    for (int i = 0; i < `GBT_NUM_IRQ; i++) begin
      if (pend[i] && !found) begin
        idx = irq_src_e'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic logic [7:0] model_read(input cpu_bus_t b);
    if (!b.read_en) begin
      return 8'hFF;
    end
    case (b.addr)
      `GBT_ADDR_DIV:  return m_div[15:8];
      `GBT_ADDR_TIMA: return m_tima;
      `GBT_ADDR_TMA:  return m_tma;
      `GBT_ADDR_TAC:  return m_tac.raw | 8'hF8;
      `GBT_ADDR_IF:   return {3'b111, m_if};
      `GBT_ADDR_IE:   return {3'b000, m_ie};
      default:        return 8'hFF;
    endcase
  endfunction

  // Advance the reference across one clock edge
  task automatic model_step(input cpu_bus_t b, input logic [4:0] e, input logic a);
    logic       step_now;
    logic       ovf;
    logic [7:0] nxt_tima;
    logic [4:0] ack_mask;
    logic [4:0] base;
    logic [4:0] req_in;
    step_now = step_due();
    ovf = step_now && (m_tima == 8'hFF) && !writes(b, `GBT_ADDR_TIMA);
    if (writes(b, `GBT_ADDR_TIMA)) begin
      nxt_tima = b.wdata;
    end else if (step_now) begin
      nxt_tima = (m_tima == 8'hFF) ? m_tma : m_tima + 8'd1;
    end else begin
      nxt_tima = m_tima;
    end
    // Timer position comes from the pulse, never from outside
    req_in = {e[4:3], m_tirq, e[1:0]};
    ack_mask = a ? (5'b00001 << model_idx()) : 5'b00000;
    base = writes(b, `GBT_ADDR_IF) ? b.wdata[4:0] : (m_if & ~ack_mask);
    m_div = writes(b, `GBT_ADDR_DIV) ? 16'h0000 : m_div + 16'd1;
    if (m_tac.fields.enable) begin
      m_presc = step_now ? 10'd0 : m_presc + 10'd1;
    end
    m_tima = nxt_tima;
    if (writes(b, `GBT_ADDR_TMA)) begin
      m_tma = b.wdata;
    end
    if (writes(b, `GBT_ADDR_TAC)) begin
      m_tac.raw = {5'b00000, b.wdata[2:0]};
    end
    m_tirq = ovf;
    m_if = base | req_in;
    if (writes(b, `GBT_ADDR_IE)) begin
      m_ie = b.wdata[4:0];
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "read data check failed");
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "interrupt line check failed");
    end
  endtask

  task automatic check_idx(input string name, input irq_src_e got, input irq_src_e exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "interrupt index check failed");
    end
  endtask

  // Outputs settled mid-cycle, then the reference moves to the next edge
  task automatic check_and_step(input cpu_bus_t b, input logic [4:0] e, input logic a);
    @(negedge clk);
    check_byte("rdata", rdata, model_read(b));
    check_irq("irq", irq, model_irq());
    check_idx("irq_idx", irq_idx, model_idx());
    model_step(b, e, a);
  endtask

  task automatic run_cycle(input cpu_bus_t b, input logic [4:0] e, input logic a);
    @(posedge clk);
    bus     <= b;
    ext_irq <= e;
    irq_ack <= a;
    check_and_step(b, e, a);
  endtask

  initial begin
    cpu_bus_t   b;
    logic [4:0] e;
    logic       a;
    int unsigned op;
    reset   = 1'b1;
    bus     = '0;
    ext_irq = 5'b00000;
    irq_ack = 1'b0;
    m_div   = '0;
    m_presc = '0;
    m_tima  = '0;
    m_tma   = '0;
    m_tac   = '0;
    m_tirq  = 1'b0;
    m_if    = '0;
    m_ie    = '0;
    void'($urandom(32'h7c91));
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    check_and_step('0, 5'b00000, 1'b0);

    // Read map straight after reset
    for (int k = 0; k < 6; k++) begin
      run_cycle(read_req(reg_addr(k)), 5'b00000, 1'b0);
    end
    repeat (6) run_cycle(read_req(16'($urandom)), 5'b00000, 1'b0);
    b = '0;
    b.addr = `GBT_ADDR_TIMA;
    run_cycle(b, 5'b00000, 1'b0);
    b.addr = `GBT_ADDR_IF;
    run_cycle(b, 5'b00000, 1'b0);

    // Each rate in turn, TIMA writes thrown at step edges
    for (int r = 0; r < 4; r++) begin
      run_cycle(write_req(`GBT_ADDR_TAC, 8'h04 | 8'(r)), 5'b00000, 1'b0);
      repeat (3 * (int'(limit_of(2'(r))) + 1) + 24) begin
        if (step_due() && ($urandom % 2 == 0)) begin
          b = write_req(`GBT_ADDR_TIMA, 8'($urandom));
        end else if ($urandom % 4 == 0) begin
          b = read_req(`GBT_ADDR_DIV);
        end else begin
          b = read_req(`GBT_ADDR_TIMA);
        end
        run_cycle(b, 5'b00000, 1'b0);
      end
      // Disabled, TIMA must hold
      run_cycle(write_req(`GBT_ADDR_TAC, 8'($urandom) & 8'hFB), 5'b00000, 1'b0);
      repeat (HOLD_CYCLES) run_cycle(read_req(`GBT_ADDR_TIMA), 5'b00000, 1'b0);
    end

    // Overflow into TMA and the timer flag
    run_cycle(write_req(`GBT_ADDR_TMA, 8'($urandom)), 5'b00000, 1'b0);
    run_cycle(write_req(`GBT_ADDR_TIMA, 8'hFD), 5'b00000, 1'b0);
    run_cycle(write_req(`GBT_ADDR_IE, 8'h1F), 5'b00000, 1'b0);
    run_cycle(write_req(`GBT_ADDR_IF, 8'h00), 5'b00000, 1'b0);
    run_cycle(write_req(`GBT_ADDR_TAC, 8'h05), 5'b00000, 1'b0);
    repeat (OVF_CYCLES - 5) begin
      b = ($urandom % 2 == 0) ? read_req(`GBT_ADDR_IF) : read_req(`GBT_ADDR_TIMA);
      run_cycle(b, 5'b00000, 1'b0);
    end

    // Mixed traffic, sparse pulses, acks only while irq is up
    repeat (RANDOM_CYCLES) begin
      op = $urandom % 8;
      if ($urandom % 100 < 85) begin
        b = read_req(reg_addr($urandom));
      end else begin
        b = read_req(16'($urandom));
      end
      if (op < 2) begin
        b = write_req(b.addr, 8'($urandom));
      end else if (op == 7) begin
        b.read_en = 1'b0;
      end
      e = ($urandom % 16 == 0) ? (5'b00001 << ($urandom % 5)) : 5'b00000;
      a = model_irq() && ($urandom % 3 == 0);
      // Same-source request racing the ack
      if (a && ($urandom % 4 == 0)) begin
        e = e | (5'b00001 << model_idx());
      end
      run_cycle(b, e, a);
    end

    $display(">>> PASS");
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
    $display("timeout: stimulus did not finish in %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/gbt_pkg.sv
verilog/gbt_bus_fabric.sv
verilog/gbt_timer.sv
verilog/gbt_int_ctrl.sv
verilog/gbt_timer_subsys.sv
sim/tb_gbt_timer_subsys.sv
